// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module cpu_tb -f cpu.f -o cpu_sim

run: compile
	./obj_dir/cpu_sim | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== alu.sv ====
module alu import isa_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_not: result = ~a;
            // Shift by one only
            alu_shl: result = {a[word_size-2:0], 1'b0};
            alu_shr: result = {a[word_size-1], a[word_size-1:1]};
            // Immediate goes to the upper byte, lower byte cleared
            alu_lhi: result = {b[imm_w-1:0], {imm_w{1'b0}}};
            default: result = '0;
        endcase
    end

endmodule

// ==== branch_calculator.sv ====
module branch_calculator import isa_pkg::*; (
    input  branch_kind_t kind,
    input  word_t        rs_val,
    input  word_t        rt_val,
    input  word_t        next_pc,
    input  word_t        instr,
    output logic         taken,
    output word_t        target
);

    word_t cur_pc;
    word_t offset;
    logic  is_jump;

    assign cur_pc = next_pc - word_t'(1);
    assign offset = {{(word_size-imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]};
    assign is_jump = (kind == br_jmp) || (kind == br_jal);

    always_comb begin
        case (kind)
            br_bne:         taken = (rs_val != rt_val);
            br_beq:         taken = (rs_val == rt_val);
            br_bgz:         taken = ($signed(rs_val) > 0);
            br_blz:         taken = ($signed(rs_val) < 0);
            br_jmp, br_jal: taken = 1'b1;
            default:        taken = 1'b0;
        endcase
    end

    // Jumps keep the page bits of the jump's own address
    assign target = is_jump ? {cur_pc[word_size-1:target_w], instr[target_w-1:0]}
                            : next_pc + offset;

endmodule

// ==== control_unit.sv ====
module control_unit import isa_pkg::*, pipe_pkg::*; (
    input  word_t instr,
    output ctrl_t ctrl
);

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rt_idx;
    reg_idx_t rd_idx;

    assign opcode = instr[op_lsb +: op_w];
    assign funct = instr[funct_w-1:0];
    assign rt_idx = instr[rt_lsb +: reg_idx_w];
    assign rd_idx = instr[rd_lsb +: reg_idx_w];

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = alu_add;
        ctrl.branch = br_none;
        ctrl.valid = 1'b1;
        case (opcode)
            op_bne: ctrl.branch = br_bne;
            op_beq: ctrl.branch = br_beq;
            op_bgz: ctrl.branch = br_bgz;
            op_blz: ctrl.branch = br_blz;
            op_jmp: ctrl.branch = br_jmp;
            op_adi, op_ori, op_lhi, op_lwd: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest = rt_idx;
                ctrl.mem_read = (opcode == op_lwd);
                if (opcode == op_ori) ctrl.alu_op = alu_or;
                if (opcode == op_lhi) ctrl.alu_op = alu_lhi;
            end
            op_swd: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_jal: begin
                ctrl.branch = br_jal;
                ctrl.reg_write = 1'b1;
                ctrl.dest = link_reg;
                ctrl.pc_to_reg = 1'b1;
            end
            op_rtype: begin
                ctrl.reg_write = 1'b1;
                ctrl.dest = rd_idx;
                case (funct)
                    fn_add: ctrl.alu_op = alu_add;
                    fn_sub: ctrl.alu_op = alu_sub;
                    fn_and: ctrl.alu_op = alu_and;
                    fn_orr: ctrl.alu_op = alu_or;
                    fn_not: ctrl.alu_op = alu_not;
                    fn_shl: ctrl.alu_op = alu_shl;
                    fn_shr: ctrl.alu_op = alu_shr;
                    fn_wwd: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.wwd = 1'b1;
                    end
                    fn_hlt: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.halt = 1'b1;
                    end
                    default: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.valid = 1'b0;
                    end
                endcase
            end
            // Unknown opcode becomes a bubble
            default: ctrl.valid = 1'b0;
        endcase
    end

endmodule

// ==== cpu.f ====
isa_pkg.sv
pipe_pkg.sv
control_unit.sv
register_file.sv
alu.sv
branch_calculator.sv
hazard_detect.sv
pipe_stage.sv
cpu.sv
cpu_properties.sv
cpu_tb.sv

// ==== cpu.sv ====
module cpu import isa_pkg::*, pipe_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    output logic  read_m1,
    output word_t address1,
    input  word_t data1,
    output logic  read_m2,
    output logic  write_m2,
    output word_t address2,
    output word_t write_data2,
    input  word_t read_data2,
    output word_t num_inst,
    output word_t output_port,
    output logic  wwd_valid,
    output logic  is_halted
);

    word_t        pc;
    logic         started;
    logic         halt_pending;
    word_t        out_reg;

    if_id_t       if_id_d, if_id_q;
    id_ex_t       id_ex_d, id_ex_q;
    ex_mem_t      ex_mem_d, ex_mem_q;
    mem_wb_t      mem_wb_d, mem_wb_q;

    ctrl_t        dec_ctrl;
    branch_kind_t br_kind;
    word_t        rs_val, rt_val;
    word_t        imm_ext;
    word_t        br_target;
    word_t        alu_b, alu_out;
    word_t        wb_data;
    logic         stall_raw, stall;
    logic         taken_raw, taken;
    logic         halt_decode;
    logic         retire;
    logic         wb_en;

    ////////////////////////////////////////
    // Fetch

    // Fetch stops once HLT has left decode
    assign read_m1 = started && !halt_pending;
    assign address1 = pc;

    assign if_id_d.instr = read_m1 ? data1 : '0;
    assign if_id_d.next_pc = pc + word_t'(1);
    assign if_id_d.valid = read_m1;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc <= '0;
            started <= 1'b0;
            halt_pending <= 1'b0;
        end else begin
            started <= 1'b1;
            if (halt_decode) halt_pending <= 1'b1;
            if (taken) begin
                pc <= br_target;
            end else if (read_m1 && !stall) begin
                pc <= if_id_d.next_pc;
            end
        end
    end

    pipe_stage #(.payload_t(if_id_t)) if_id (
        .clk(clk), .reset_n(reset_n), .stall(stall),
        .flush(taken || halt_decode), .d(if_id_d), .q(if_id_q)
    );

    ////////////////////////////////////////
    // Decode

    control_unit u_control (.instr(if_id_q.instr), .ctrl(dec_ctrl));

    register_file u_regs (
        .clk(clk), .reset_n(reset_n),
        .rs_idx(if_id_q.instr[rs_lsb +: reg_idx_w]),
        .rt_idx(if_id_q.instr[rt_lsb +: reg_idx_w]),
        .wr_idx(mem_wb_q.ctrl.dest), .wr_en(wb_en), .wr_data(wb_data),
        .rs_data(rs_val), .rt_data(rt_val)
    );

    hazard_detect u_hazard (
        .instr(if_id_q.instr), .id_ex_ctrl(id_ex_q.ctrl),
        .ex_mem_ctrl(ex_mem_q.ctrl), .stall(stall_raw)
    );

    assign stall = stall_raw && if_id_q.valid;
    assign br_kind = if_id_q.valid ? dec_ctrl.branch : br_none;

    branch_calculator u_branch (
        .kind(br_kind), .rs_val(rs_val), .rt_val(rt_val),
        .next_pc(if_id_q.next_pc), .instr(if_id_q.instr),
        .taken(taken_raw), .target(br_target)
    );

    // Branch waits for its operands
    assign taken = taken_raw && !stall;
    assign halt_decode = if_id_q.valid && dec_ctrl.valid && dec_ctrl.halt && !stall;

    // ORI takes a zero-extended immediate
    assign imm_ext = (if_id_q.instr[op_lsb +: op_w] == op_ori)
        ? {{(word_size-imm_w){1'b0}}, if_id_q.instr[imm_w-1:0]}
        : {{(word_size-imm_w){if_id_q.instr[imm_w-1]}}, if_id_q.instr[imm_w-1:0]};

    always_comb begin
        id_ex_d.ctrl = dec_ctrl;
        id_ex_d.ctrl.valid = dec_ctrl.valid && if_id_q.valid;
        id_ex_d.rs_val = rs_val;
        id_ex_d.rt_val = rt_val;
        id_ex_d.imm = imm_ext;
        id_ex_d.next_pc = if_id_q.next_pc;
    end

    // Stall inserts a bubble into execute
    pipe_stage #(.payload_t(id_ex_t)) id_ex (
        .clk(clk), .reset_n(reset_n), .stall(1'b0),
        .flush(stall), .d(id_ex_d), .q(id_ex_q)
    );

    ////////////////////////////////////////
    // Execute

    assign alu_b = id_ex_q.ctrl.alu_src_imm ? id_ex_q.imm : id_ex_q.rt_val;

    alu u_alu (.op(id_ex_q.ctrl.alu_op), .a(id_ex_q.rs_val), .b(alu_b), .result(alu_out));

    assign ex_mem_d.ctrl = id_ex_q.ctrl;
    assign ex_mem_d.alu_result = alu_out;
    assign ex_mem_d.store_val = id_ex_q.rt_val;
    assign ex_mem_d.rs_val = id_ex_q.rs_val;
    assign ex_mem_d.next_pc = id_ex_q.next_pc;

    pipe_stage #(.payload_t(ex_mem_t)) ex_mem (
        .clk(clk), .reset_n(reset_n), .stall(1'b0),
        .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q)
    );

    ////////////////////////////////////////
    // Memory

    assign read_m2 = ex_mem_q.ctrl.valid && ex_mem_q.ctrl.mem_read;
    assign write_m2 = ex_mem_q.ctrl.valid && ex_mem_q.ctrl.mem_write;
    assign address2 = ex_mem_q.alu_result;
    assign write_data2 = ex_mem_q.store_val;

    assign mem_wb_d.ctrl = ex_mem_q.ctrl;
    assign mem_wb_d.alu_result = ex_mem_q.alu_result;
    assign mem_wb_d.mem_data = read_data2;
    assign mem_wb_d.wwd_value = ex_mem_q.rs_val;
    assign mem_wb_d.next_pc = ex_mem_q.next_pc;

    pipe_stage #(.payload_t(mem_wb_t)) mem_wb (
        .clk(clk), .reset_n(reset_n), .stall(1'b0),
        .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
    );

    ////////////////////////////////////////
    // Write-back

    assign retire = mem_wb_q.ctrl.valid;
    assign wb_en = retire && mem_wb_q.ctrl.reg_write;
    assign wb_data = mem_wb_q.ctrl.pc_to_reg ? mem_wb_q.next_pc
                   : mem_wb_q.ctrl.mem_read  ? mem_wb_q.mem_data
                   : mem_wb_q.alu_result;

    assign wwd_valid = retire && mem_wb_q.ctrl.wwd;
    assign output_port = wwd_valid ? mem_wb_q.wwd_value : out_reg;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst <= '0;
            out_reg <= '0;
            is_halted <= 1'b0;
        end else begin
            if (retire) num_inst <= num_inst + word_t'(1);
            if (wwd_valid) out_reg <= mem_wb_q.wwd_value;
            if (retire && mem_wb_q.ctrl.halt) is_halted <= 1'b1;
        end
    end

endmodule

// ==== cpu_properties.sv ====
module cpu_properties import isa_pkg::*; (
    input logic  clk,
    input logic  reset_n,
    input logic  read_m2,
    input logic  write_m2,
    input logic  wwd_valid,
    input logic  is_halted,
    input word_t num_inst
);

    timeunit 1ns;
    timeprecision 1ps;

    // Data port does one access per cycle
    mem_exclusive: assert property (
        @(posedge clk) disable iff (reset_n) !(read_m2 && write_m2)
    ) else $error("read_m2 and write_m2 high in the same cycle");

    // Nothing reaches the output port once halted
    quiet_after_halt: assert property (
        @(posedge clk) disable iff (reset_n) is_halted |-> !wwd_valid
    ) else $error("wwd_valid high while is_halted is high");

    count_monotonic: assert property (
        @(posedge clk) disable iff (reset_n) !$past(reset_n) |-> num_inst >= $past(num_inst)
    ) else $error("num_inst decreased outside reset");

endmodule

bind cpu cpu_properties u_props (.*);

// ==== cpu_stimulus.txt ====
# test <name>, p <instruction word>, d <addr> <data>, o <expected WWD value>
# m <addr> <expected data word>, n <expected num_inst>, end; all values hex
test alu_imm
p 4105 p 4203 p F6C0 p FC1C p F6C1 p FC1C p F6C2 p FC1C p F6C3 p FC1C
p F4C4 p FC1C p F4C6 p FC1C p 4080 p F0C7 p FC1C p 59F0 p F41C p 6212
p F81C p F01D
o 0008 o 0002 o 0001 o 0007 o FFFA o 000A o FFC0 o 00F3 o 1200
n 16
end
test load_store
p 7110 p F41C p 4601 p 8220 p 7320 p FC1C p 8321 p F01D
d 10 1234
o 1234 o 1235
m 10 1234 m 20 1235 m 21 1235
n 8
end
test branch_jump
p 4101 p 42FF p 0601 p F01C p 1601 p F41C p 2401 p F01C p 3801 p F01C
p 2801 p F81C p A010 p F01C p F01C p F01C p F81C p 9014 p F01C p F01C
p 3401 p F41C p F01D
o 0001 o FFFF o 000D o 0001
n F
end
test dependency
p 4103 p F540 p F540 p 8130 p 7230 p F9C0 p FC1C p FE01 p 2001 p F01C
p F01C p F01D
o 0018 o 000C
m 30 000C
n B
end
test halt_count
p 4107 p F41C p F01D p F41C p 4105 p F41C
o 0007
n 3
end

// ==== cpu_tb.sv ====
module cpu_tb import isa_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    logic  clk;
    logic  reset_n;
    logic  read_m1;
    word_t address1;
    word_t data1;
    logic  read_m2;
    logic  write_m2;
    word_t address2;
    word_t write_data2;
    word_t read_data2;
    word_t num_inst;
    word_t output_port;
    logic  wwd_valid;
    logic  is_halted;

    word_t imem [256];
    word_t dmem [256];

    word_t exp_out [$];
    int    exp_addr [$];
    word_t exp_val [$];
    word_t exp_count;
    string test_name;
    int    fd;
    int    errors;
    int    tests_run;
    int    tests_failed;
    logic  checking;

    cpu UUT (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    ////////////////////////////////////////
    // Memory models

    assign data1 = read_m1 ? imem[address1[7:0]] : '0;
    assign read_data2 = read_m2 ? dmem[address2[7:0]] : '0;

    always @(posedge clk) begin
        if (write_m2) dmem[address2[7:0]] <= write_data2;
    end

    ////////////////////////////////////////
    // Checks

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %04h, expected %04h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] num_inst: got %04h, expected %04h", got, exp);
            errors++;
        end
    endtask

    // Output port sampled away from the active edge
    always @(negedge clk) begin
        if (checking && !reset_n && wwd_valid) begin
            if (exp_out.size() == 0) begin
                $display("Test %s produced an output that was not expected", test_name);
                errors++;
            end else begin
                check_word("output_port", output_port, exp_out.pop_front());
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus file reader

    task automatic load_test(output bit found);
        string tok;
        string rest;
        int    code;
        int    a;
        int    v;
        int    fill;
        found = 1'b0;
        fill = 0;
        exp_out.delete();
        exp_addr.delete();
        exp_val.delete();
        exp_count = '0;
        // Unused words decode as bubbles, data words are traceable by address
        for (int i = 0; i < 256; i++) begin
            imem[i] = {4'hE, 4'h0, i[7:0]};
            dmem[i] <= {i[7:0], ~i[7:0]};
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) return;
            case (tok)
                "#": code = $fgets(rest, fd);
                "test": begin
                    code = $fscanf(fd, "%s", test_name);
                    found = 1'b1;
                end
                "p": begin
                    code = $fscanf(fd, "%h", v);
                    imem[fill] = word_t'(v);
                    fill++;
                end
                "d": begin
                    code = $fscanf(fd, "%h %h", a, v);
                    dmem[a[7:0]] <= word_t'(v);
                end
                "o": begin
                    code = $fscanf(fd, "%h", v);
                    exp_out.push_back(word_t'(v));
                end
                "m": begin
                    code = $fscanf(fd, "%h %h", a, v);
                    exp_addr.push_back(a);
                    exp_val.push_back(word_t'(v));
                end
                "n": begin
                    code = $fscanf(fd, "%h", v);
                    exp_count = word_t'(v);
                end
                "end": return;
                default: begin
                    $display("Unknown token %s in stimulus file", tok);
                    errors++;
                end
            endcase
        end
    endtask

    ////////////////////////////////////////
    // Test sequence

    task automatic run_test();
        int cycles;
        int start_errors;
        start_errors = errors;
        @(posedge clk);
        reset_n <= 1'b1;
        for (int i = 0; i < 10; i++) @(posedge clk);
        reset_n <= 1'b0;
        checking = 1'b1;
        cycles = 0;
        while (!is_halted && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (!is_halted) begin
            $display("Test %s timed out waiting for is_halted", test_name);
            errors++;
        end
        // Watch a while longer for stray outputs
        cycles = 0;
        while (cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        checking = 1'b0;
        if (exp_out.size() != 0) begin
            $display("Test %s is missing %0d expected outputs", test_name, exp_out.size());
            errors++;
        end
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_word($sformatf("dmem[%02h]", exp_addr[i]), dmem[exp_addr[i][7:0]], exp_val[i]);
        end
        check_count(num_inst, exp_count);
        tests_run++;
        if (errors == start_errors) begin
            $display("Test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", test_name, errors - start_errors);
        end
    endtask

    initial begin
        bit found;
        reset_n = 1'b1;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        checking = 1'b0;
        fd = $fopen("cpu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open cpu_stimulus.txt");
            $display("tests failed");
            $finish;
        end else begin
            load_test(found);
            while (found) begin
                run_test();
                load_test(found);
            end
            $fclose(fd);
            $display("%0d tests run, %0d passed, %0d failed",
                     tests_run, tests_run - tests_failed, tests_failed);
            if (errors == 0 && tests_run > 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

// ==== hazard_detect.sv ====
module hazard_detect import isa_pkg::*, pipe_pkg::*; (
    input  word_t instr,
    input  ctrl_t id_ex_ctrl,
    input  ctrl_t ex_mem_ctrl,
    output logic  stall
);

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    logic     reads_rs;
    logic     reads_rt;
    logic     rs_busy;
    logic     rt_busy;

    assign opcode = instr[op_lsb +: op_w];
    assign funct = instr[funct_w-1:0];
    assign rs_idx = instr[rs_lsb +: reg_idx_w];
    assign rt_idx = instr[rt_lsb +: reg_idx_w];

    // Source registers actually read by the decoded instruction
    always_comb begin
        reads_rs = 1'b0;
        reads_rt = 1'b0;
        case (opcode)
            op_bne, op_beq, op_swd: begin
                reads_rs = 1'b1;
                reads_rt = 1'b1;
            end
            op_bgz, op_blz, op_adi, op_ori, op_lwd: reads_rs = 1'b1;
            op_rtype: begin
                reads_rs = (funct != fn_hlt);
                reads_rt = (funct == fn_add) || (funct == fn_sub) ||
                           (funct == fn_and) || (funct == fn_orr);
            end
            default: ;
        endcase
    end

    function automatic logic writes_to(ctrl_t c, reg_idx_t idx);
        return c.valid && c.reg_write && (c.dest == idx);
    endfunction

    assign rs_busy = writes_to(id_ex_ctrl, rs_idx) || writes_to(ex_mem_ctrl, rs_idx);
    assign rt_busy = writes_to(id_ex_ctrl, rt_idx) || writes_to(ex_mem_ctrl, rt_idx);
    assign stall = (reads_rs && rs_busy) || (reads_rt && rt_busy);

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

    localparam int word_size = 16;
    localparam int reg_count = 4;
    localparam int reg_idx_w = $clog2(reg_count);

    typedef logic [word_size-1:0] word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // Field positions, given as lowest bit and width
    localparam int op_lsb = 12;
    localparam int op_w = 4;
    localparam int rs_lsb = 10;
    localparam int rt_lsb = 8;
    localparam int rd_lsb = 6;
    localparam int funct_w = 6;
    localparam int imm_w = 8;
    localparam int target_w = 12;

    typedef logic [op_w-1:0] opcode_t;
    typedef logic [funct_w-1:0] funct_t;

    // JAL link register
    localparam reg_idx_t link_reg = 2'd2;

    localparam opcode_t op_bne = 4'd0;
    localparam opcode_t op_beq = 4'd1;
    localparam opcode_t op_bgz = 4'd2;
    localparam opcode_t op_blz = 4'd3;
    localparam opcode_t op_adi = 4'd4;
    localparam opcode_t op_ori = 4'd5;
    localparam opcode_t op_lhi = 4'd6;
    localparam opcode_t op_lwd = 4'd7;
    localparam opcode_t op_swd = 4'd8;
    localparam opcode_t op_jmp = 4'd9;
    localparam opcode_t op_jal = 4'd10;
    localparam opcode_t op_rtype = 4'd15;

    // Function codes under op_rtype
    localparam funct_t fn_add = 6'd0;
    localparam funct_t fn_sub = 6'd1;
    localparam funct_t fn_and = 6'd2;
    localparam funct_t fn_orr = 6'd3;
    localparam funct_t fn_not = 6'd4;
    localparam funct_t fn_shl = 6'd6;
    localparam funct_t fn_shr = 6'd7;
    localparam funct_t fn_wwd = 6'd28;
    localparam funct_t fn_hlt = 6'd29;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_not,
        alu_shl,
        alu_shr,
        alu_lhi
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none,
        br_bne,
        br_beq,
        br_bgz,
        br_blz,
        br_jmp,
        br_jal
    } branch_kind_t;

endpackage

// ==== pipe_pkg.sv ====
package pipe_pkg;

    import isa_pkg::*;

    // Decoded control, carried down the pipe with each instruction
    typedef struct packed {
        alu_op_t      alu_op;
        logic         alu_src_imm;
        logic         mem_read;
        logic         mem_write;
        logic         reg_write;
        reg_idx_t     dest;
        logic         pc_to_reg;
        logic         wwd;
        logic         halt;
        branch_kind_t branch;
        logic         valid;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t next_pc;
        logic  valid;
    } if_id_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t rs_val;
        word_t rt_val;
        word_t imm;
        word_t next_pc;
    } id_ex_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t alu_result;
        word_t store_val;
        word_t rs_val;
        word_t next_pc;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t alu_result;
        word_t mem_data;
        word_t wwd_value;
        word_t next_pc;
    } mem_wb_t;

endpackage

// ==== pipe_stage.sv ====
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // All-zero payload has valid cleared
    always_ff @(posedge clk) begin
        if (reset_n || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

// ==== register_file.sv ====
module register_file import isa_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  reg_idx_t wr_idx,
    input  logic     wr_en,
    input  word_t    wr_data,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Bypass the write port so decode sees a same-cycle write-back
    assign rs_data = (wr_en && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
    assign rt_data = (wr_en && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

endmodule
